/* fetch_top.f */
+incdir+src
src/fetch_pkg.sv
src/fetch_pc.sv
src/icache_store.sv
src/icache_ctrl.sv
src/fetch_top.sv
verif/tb_clock.sv
verif/axi_mem_model.sv
verif/tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_fetch_top -Mdir obj_dir -o tb_fetch_top -f fetch_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_top > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

/* src/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// fetch address and instruction width
`define FETCH_ADDR_W 32

// words per cache line, also the burst length
`define ICACHE_LINE_WORDS 4

// number of lines, 2, 4 or 8
`define ICACHE_SETS 2

// first pc after reset
`define FETCH_RESET_PC 32'h8000_0000

// derived field widths
`define ICACHE_WORD_BITS $clog2(`ICACHE_LINE_WORDS)
`define ICACHE_INDEX_BITS $clog2(`ICACHE_SETS)
`define ICACHE_TAG_BITS (`FETCH_ADDR_W - `ICACHE_INDEX_BITS - `ICACHE_WORD_BITS - 2)
`define ICACHE_LINE_BASE_BITS (`FETCH_ADDR_W - `ICACHE_WORD_BITS - 2)

`endif

/* src/fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_pc (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      redirect,
    input  wire [`FETCH_ADDR_W-1:0]  redirect_pc,
    input  wire                      fetch_stall,
    output fetch_pkg::fetch_addr_t   fetch_addr,
    output logic                     fetch_req
);

    // next pc to present to the cache
    logic [`FETCH_ADDR_W-1:0] pc_q;
    // request enable, one dead cycle after reset and after redirect
    logic                     req_q;
    // address taken by the cache this cycle
    logic                     advance;

    assign advance = fetch_req && !fetch_stall;

    // word aligned pc register
    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (redirect) begin
            // low bits forced to a word boundary
            pc_q <= {redirect_pc[`FETCH_ADDR_W-1:2], 2'b00};
        end else if (advance) begin
            pc_q <= pc_q + `FETCH_ADDR_W'(4);
        end
    end

    // request goes quiet for the cycle in which a new pc settles
    always_ff @(posedge clock) begin
        if (reset) begin
            req_q <= 1'b0;
        end else if (redirect) begin
            req_q <= 1'b0;
        end else begin
            req_q <= 1'b1;
        end
    end

    assign fetch_addr = pc_q;
    assign fetch_req  = req_q;

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none
`include "fetch_config.svh"

package fetch_pkg;

    // lookup view: tag, set index, word in line, byte in word
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        logic [`ICACHE_INDEX_BITS-1:0] index;
        logic [`ICACHE_WORD_BITS-1:0]  word;
        logic [1:0]                    byte_off;
    } lookup_fields_t;

    // refill view: line aligned base plus byte offset inside the line
    typedef struct packed {
        logic [`ICACHE_LINE_BASE_BITS-1:0] line_base;
        logic [`ICACHE_WORD_BITS+1:0]      line_off;
    } refill_fields_t;

    // one fetch address, decoded both ways
    typedef union packed {
        lookup_fields_t lookup;
        refill_fields_t refill;
    } fetch_addr_t;

    // miss handling states of the cache controller
    typedef enum logic [1:0] {IDLE, CANCEL_WAIT, AR_WAIT, R_BURST} icache_state_t;

endpackage

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_top (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          redirect,
    input  wire [`FETCH_ADDR_W-1:0]      redirect_pc,
    input  wire                          fence_i,
    input  wire                          hold,
    output logic [`FETCH_ADDR_W-1:0]     araddr,
    output logic                         arvalid,
    input  wire                          arready,
    input  wire [`FETCH_ADDR_W-1:0]      rdata,
    input  wire                          rvalid,
    input  wire                          rlast,
    output logic [`FETCH_ADDR_W-1:0]     inst,
    output logic [`FETCH_ADDR_W-1:0]     inst_pc,
    output logic                         inst_valid
);

    import fetch_pkg::*;

    // pc unit to controller
    fetch_addr_t                   fetch_addr;
    logic                          fetch_req;
    logic                          fetch_stall;
    // controller to store, lookup side
    logic [`ICACHE_INDEX_BITS-1:0] lookup_index;
    logic [`ICACHE_WORD_BITS-1:0]  lookup_word;
    logic                          hit_valid;
    logic [`ICACHE_TAG_BITS-1:0]   hit_tag;
    logic [`FETCH_ADDR_W-1:0]      hit_word;
    // controller to store, refill side
    logic                          refill_we;
    logic [`ICACHE_INDEX_BITS-1:0] refill_index;
    logic [`ICACHE_WORD_BITS-1:0]  refill_word;
    logic [`ICACHE_TAG_BITS-1:0]   refill_tag;
    logic [`FETCH_ADDR_W-1:0]      refill_data;
    logic                          refill_done;

    fetch_pc u_fetch_pc (.clock, .reset, .redirect, .redirect_pc, .fetch_stall,
        .fetch_addr, .fetch_req);

    icache_ctrl u_icache_ctrl (.clock, .reset, .redirect, .fence_i, .hold,
        .fetch_addr, .fetch_req, .hit_valid, .hit_tag, .hit_word,
        .arready, .rdata, .rvalid, .rlast, .fetch_stall, .lookup_index, .lookup_word,
        .refill_we, .refill_index, .refill_word, .refill_tag, .refill_data, .refill_done,
        .araddr, .arvalid, .inst, .inst_pc, .inst_valid);

    // fence_i reaches the store directly
    icache_store u_icache_store (.clock, .reset, .fence_i, .lookup_index, .lookup_word,
        .refill_we, .refill_index, .refill_word, .refill_tag, .refill_data, .refill_done,
        .hit_valid, .hit_tag, .hit_word);

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module icache_ctrl (
    input  wire                              clock,
    input  wire                              reset,
    input  wire                              redirect,
    input  wire                              fence_i,
    input  wire                              hold,
    input  wire fetch_pkg::fetch_addr_t      fetch_addr,
    input  wire                              fetch_req,
    input  wire                              hit_valid,
    input  wire [`ICACHE_TAG_BITS-1:0]       hit_tag,
    input  wire [`FETCH_ADDR_W-1:0]          hit_word,
    input  wire                              arready,
    input  wire [`FETCH_ADDR_W-1:0]          rdata,
    input  wire                              rvalid,
    input  wire                              rlast,
    output logic                             fetch_stall,
    output logic [`ICACHE_INDEX_BITS-1:0]    lookup_index,
    output logic [`ICACHE_WORD_BITS-1:0]     lookup_word,
    output logic                             refill_we,
    output logic [`ICACHE_INDEX_BITS-1:0]    refill_index,
    output logic [`ICACHE_WORD_BITS-1:0]     refill_word,
    output logic [`ICACHE_TAG_BITS-1:0]      refill_tag,
    output logic [`FETCH_ADDR_W-1:0]         refill_data,
    output logic                             refill_done,
    output logic [`FETCH_ADDR_W-1:0]         araddr,
    output logic                             arvalid,
    output logic [`FETCH_ADDR_W-1:0]         inst,
    output logic [`FETCH_ADDR_W-1:0]         inst_pc,
    output logic                             inst_valid
);

    import fetch_pkg::*;

    icache_state_t                     state;
    // line base of the missing address
    logic [`ICACHE_LINE_BASE_BITS-1:0] miss_line;
    // miss line rebuilt as a full address
    fetch_addr_t                       line_addr;
    // beat number inside the burst
    logic [`ICACHE_WORD_BITS-1:0]      beat_cnt;
    logic                              hit;
    logic                              accept;
    logic                              start_miss;
    logic                              ar_fire;
    // registered output valid, before the redirect mask
    logic                              valid_q;

    // probe the store with the lookup view
    assign lookup_index = fetch_addr.lookup.index;
    assign lookup_word  = fetch_addr.lookup.word;
    assign hit = fetch_req && hit_valid && (hit_tag == fetch_addr.lookup.tag);

    // hits only taken from idle, never under hold, redirect or fence
    assign accept      = (state == IDLE) && hit && !hold && !redirect && !fence_i;
    assign fetch_stall = !accept;

    // miss on a live request starts the refill sequence
    assign start_miss = (state == IDLE) && fetch_req && !hit && !hold && !redirect;

    // line aligned address via the refill view
    always_comb begin
        line_addr                  = '0;
        line_addr.refill.line_base = miss_line;
    end

    // read address channel
    assign araddr  = line_addr;
    assign arvalid = (state == AR_WAIT);
    assign ar_fire = arvalid && arready;

    // store write port, rready is tied high so every beat is taken
    assign refill_we    = (state == R_BURST) && rvalid;
    assign refill_done  = refill_we && rlast;
    assign refill_index = line_addr.lookup.index;
    assign refill_tag   = line_addr.lookup.tag;
    assign refill_word  = beat_cnt;
    assign refill_data  = rdata;

    // miss state machine
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start_miss) begin
                        state <= CANCEL_WAIT;
                    end
                end
                CANCEL_WAIT: begin
                    // a late redirect drops the miss before any burst
                    if (redirect) begin
                        state <= IDLE;
                    end else begin
                        state <= AR_WAIT;
                    end
                end
                AR_WAIT: begin
                    // arvalid held until the slave takes it
                    if (ar_fire) begin
                        state <= R_BURST;
                    end
                end
                R_BURST: begin
                    if (refill_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // line base captured on the miss cycle
    always_ff @(posedge clock) begin
        if (start_miss) begin
            miss_line <= fetch_addr.refill.line_base;
        end
    end

    // beats arrive in order from word 0
    always_ff @(posedge clock) begin
        if (reset || ar_fire) begin
            beat_cnt <= '0;
        end else if (refill_we) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // output stage, loaded only by accepted hits
    always_ff @(posedge clock) begin
        if (accept) begin
            inst    <= hit_word;
            inst_pc <= fetch_addr;
        end
    end

    // valid kept under hold, cleared by redirect or fence_i
    always_ff @(posedge clock) begin
        if (reset || redirect || fence_i) begin
            valid_q <= 1'b0;
        end else if (!hold) begin
            valid_q <= accept;
        end
    end

    // old path masked in the redirect cycle itself
    assign inst_valid = valid_q && !redirect;

endmodule

`default_nettype wire

/* src/icache_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module icache_store (
    input  wire                              clock,
    input  wire                              reset,
    input  wire                              fence_i,
    input  wire [`ICACHE_INDEX_BITS-1:0]     lookup_index,
    input  wire [`ICACHE_WORD_BITS-1:0]      lookup_word,
    input  wire                              refill_we,
    input  wire [`ICACHE_INDEX_BITS-1:0]     refill_index,
    input  wire [`ICACHE_WORD_BITS-1:0]      refill_word,
    input  wire [`ICACHE_TAG_BITS-1:0]       refill_tag,
    input  wire [`FETCH_ADDR_W-1:0]          refill_data,
    input  wire                              refill_done,
    output logic                             hit_valid,
    output logic [`ICACHE_TAG_BITS-1:0]      hit_tag,
    output logic [`FETCH_ADDR_W-1:0]         hit_word
);

    // arrays, one entry per set
    logic [`ICACHE_TAG_BITS-1:0] tag_mem  [`ICACHE_SETS];
    logic [`FETCH_ADDR_W-1:0]    data_mem [`ICACHE_SETS][`ICACHE_LINE_WORDS];
    logic [`ICACHE_SETS-1:0]     valid_q;
    // a burst has written at least one beat
    logic                        burst_open;
    // fence_i seen during the open burst
    logic                        burst_stale;
    // line may be marked valid this cycle
    logic                        fill_ok;

    // asynchronous read, word picked by the offset
    assign hit_valid = valid_q[lookup_index];
    assign hit_tag   = tag_mem[lookup_index];
    assign hit_word  = data_mem[lookup_index][lookup_word];

    // each beat lands in its own word slot
    always_ff @(posedge clock) begin
        if (refill_we) begin
            data_mem[refill_index][refill_word] <= refill_data;
        end
    end

    assign fill_ok = refill_done && !fence_i && !burst_stale;

    always_ff @(posedge clock) begin
        if (fill_ok) begin
            tag_mem[refill_index] <= refill_tag;
        end
    end

    // fence_i wins over a finishing refill
    always_ff @(posedge clock) begin
        if (reset || fence_i) begin
            valid_q <= '0;
        end else if (fill_ok) begin
            valid_q[refill_index] <= 1'b1;
        end
    end

    // burst tracking, open from first beat to last
    always_ff @(posedge clock) begin
        if (reset) begin
            burst_open  <= 1'b0;
            burst_stale <= 1'b0;
        end else if (refill_done) begin
            burst_open  <= 1'b0;
            burst_stale <= 1'b0;
        end else begin
            if (refill_we) begin
                burst_open <= 1'b1;
            end
            if (fence_i && (burst_open || refill_we)) begin
                burst_stale <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module axi_mem_model #(
    parameter logic [31:0] seed_start = 32'h821e_3076
) (
    input  wire         clock,
    input  wire         reset,
    input  wire  [31:0] araddr,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic        rlast
);

    integer      seed;
    // line address of the burst being served
    logic [31:0] base;
    int          gap;

    // contents of every word, a fixed hash of its word address
    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr >> 2) * 32'h9e37_79b1;
        return h ^ (h >> 15) ^ 32'h5a5a_1234;
    endfunction

    // outputs move 1 ns after the rising edge
    task automatic next_edge();
        @(posedge clock);
        #1;
    endtask

    initial begin
        seed    = seed_start;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clock);
            if (!reset && arvalid) begin
                base = araddr;
                // address taken after a random wait
                gap = $unsigned($random(seed)) % 4;
                repeat (gap + 1) next_edge();
                arready = 1'b1;
                next_edge();
                arready = 1'b0;
                // beats in order, random bubbles between them
                for (int beat = 0; beat < `ICACHE_LINE_WORDS; beat++) begin
                    gap = $unsigned($random(seed)) % 3;
                    repeat (gap) next_edge();
                    rdata  = word_hash(base + 32'(beat * 4));
                    rvalid = 1'b1;
                    rlast  = (beat == `ICACHE_LINE_WORDS - 1);
                    next_edge();
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 8
) (
    output logic clock
);

    // free running, starts low
    initial begin
        clock = 1'b0;
        forever begin
            #(period_ns / 2) clock = ~clock;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module tb_fetch_top;

    import fetch_pkg::*;

    localparam int planned_fetches = 400;
    // 64 cycles per fetch plus margin
    localparam int cycle_limit = 64 * planned_fetches + 200;
    localparam int line_shift = `ICACHE_WORD_BITS + 2;

    logic        clock, reset, redirect, fence_i, hold;
    logic [31:0] redirect_pc, araddr, rdata, inst, inst_pc;
    logic        arvalid, arready, rvalid, rlast, inst_valid;

    integer seed;
    int     errors, checks, delivered, cycles, hold_left, ar_count, bursts_done, beats;
    // model state: next pc, line table, open refill
    logic [31:0] exp_pc, pend_line;
    logic [31:0] m_line [`ICACHE_SETS];
    logic        m_valid [`ICACHE_SETS];
    logic        pend_stale;
    // read request raised and not yet taken, with its expected line
    logic        ar_open;
    logic [31:0] ar_line;
    // last sample, for the hold check
    logic        prev_hold, prev_valid;
    logic [31:0] prev_inst, prev_pc;

    tb_clock #(.period_ns(8)) clock_gen (.clock);

    axi_mem_model #(.seed_start(32'h821e_3076)) mem (.clock, .reset, .araddr, .arvalid,
        .arready, .rdata, .rvalid, .rlast);

    fetch_top uut (.clock, .reset, .redirect, .redirect_pc, .fence_i, .hold, .araddr,
        .arvalid, .arready, .rdata, .rvalid, .rlast, .inst, .inst_pc, .inst_valid);

    // expected memory word
    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr >> 2) * 32'h9e37_79b1;
        return h ^ (h >> 15) ^ 32'h5a5a_1234;
    endfunction

    // line of addr present in the model table
    function automatic logic line_held(input logic [31:0] addr);
        logic [31:0] line;
        line = addr >> line_shift;
        return m_valid[line % `ICACHE_SETS] && (m_line[line % `ICACHE_SETS] == line);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        icache_state_t st;
        st = uut.u_icache_ctrl.state;
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h got %h (state %s, %0t)", name, expected,
                     actual, st.name(), $time);
        end
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    // random control for one cycle, at most one of redirect, fence_i, hold
    task automatic drive_cycle();
        int pick;
        pick = $unsigned($random(seed)) % 100;
        redirect = 1'b0;
        fence_i  = 1'b0;
        if (hold_left > 0) begin
            hold_left--;
        end else begin
            hold = 1'b0;
            if (pick < 3) begin
                redirect    = 1'b1;
                // 128 byte window, lines reused and evicted
                redirect_pc = `FETCH_RESET_PC + ($unsigned($random(seed)) & 32'h7c);
            end else if (pick < 5) begin
                fence_i = 1'b1;
            end else if (pick < 10) begin
                hold      = 1'b1;
                hold_left = $unsigned($random(seed)) % 4;
            end
        end
    endtask

    // model update at the falling edge, everything settled
    always @(negedge clock) begin
        if (reset) begin
            exp_pc     = `FETCH_RESET_PC;
            m_valid    = '{default: 1'b0};
            pend_stale = 1'b0;
            beats      = 0;
            prev_hold  = 1'b0;
            ar_open    = 1'b0;
        end else begin
            // a new read request belongs to the line of the pc still waiting
            if (arvalid && !ar_open) begin
                ar_open = 1'b1;
                ar_line = exp_pc >> line_shift;
            end
            // request stays up with a steady address until taken
            if (ar_open) begin
                compare_value("arvalid", 1, arvalid);
                compare_value("araddr", ar_line << line_shift, araddr);
            end
            // outputs frozen across a held edge
            if (prev_hold && !redirect) begin
                compare_value("inst_valid", prev_valid, inst_valid);
                compare_value("inst", prev_inst, inst);
                compare_value("inst_pc", prev_pc, inst_pc);
            end
            if (redirect) compare_value("inst_valid", 0, inst_valid);
            if (inst_valid && !hold) begin
                compare_value("inst_pc", exp_pc, inst_pc);
                compare_value("inst", word_hash(exp_pc), inst);
                if (!line_held(exp_pc)) flag_error("instruction from a line not in the cache");
                exp_pc = exp_pc + 32'd4;
                delivered++;
            end
            if (redirect) exp_pc = redirect_pc;
            if (arvalid && arready) begin
                if (line_held(araddr)) flag_error("read burst for a line already cached");
                pend_line  = ar_line;
                ar_open    = 1'b0;
                pend_stale = 1'b0;
                beats      = 0;
                ar_count++;
            end
            if (fence_i) begin
                m_valid = '{default: 1'b0};
                // beats already written, line stays invalid
                if (beats > 0 || rvalid) pend_stale = 1'b1;
            end
            if (rvalid) begin
                beats++;
                if (rlast) begin
                    if (!pend_stale) begin
                        m_valid[pend_line % `ICACHE_SETS] = 1'b1;
                        m_line[pend_line % `ICACHE_SETS]  = pend_line;
                    end
                    bursts_done++;
                    beats = 0;
                end
            end
            prev_hold  = hold;
            prev_valid = inst_valid;
            prev_inst  = inst;
            prev_pc    = inst_pc;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d fetches delivered, %0d errors",
                     cycles, delivered, planned_fetches, errors);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed        = 32'h821e_3076;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        fence_i     = 1'b0;
        hold        = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        while (delivered < planned_fetches) begin
            @(posedge clock);
            #1;
            drive_cycle();
        end
        // freeze fetch, let an open burst drain
        @(posedge clock);
        #1;
        redirect = 1'b0;
        fence_i  = 1'b0;
        hold     = 1'b1;
        while (uut.u_icache_ctrl.state != IDLE) begin
            @(posedge clock);
            #1;
        end
        repeat (2) @(posedge clock);
        compare_value("ar_count", bursts_done, ar_count);
        if (ar_count < 4) flag_error("too few read bursts seen");
        $display("error count %0d after %0d checks, %0d fetches, %0d bursts", errors, checks,
                 delivered, ar_count);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
